// ==== mini_pkg.sv ====
package mini_pkg;

  // data and address widths
  typedef logic [15:0] word_t;
  typedef logic [19:0] addr_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [4:0]  uaddr_t;

  // opcodes, taken from the high byte of an instruction word
  localparam opcode_t OP_LDI  = 8'hB8;
  localparam opcode_t OP_ADDI = 8'h05;
  localparam opcode_t OP_DEC  = 8'h48;
  localparam opcode_t OP_LD   = 8'hA1;
  localparam opcode_t OP_ST   = 8'hA3;
  localparam opcode_t OP_JNZ  = 8'h75;
  localparam opcode_t OP_CLI  = 8'hFA;
  localparam opcode_t OP_STI  = 8'hFB;
  localparam opcode_t OP_IRET = 8'hCF;
  localparam opcode_t OP_HLT  = 8'hF4;

  // ip offset of the interrupt handler
  localparam word_t INT_VECTOR = 16'h0040;

  // values after reset
  localparam word_t RESET_CS = 16'h0000;
  localparam word_t RESET_IP = 16'h0100;

  typedef enum logic [2:0] {
    S_OPCODE,
    S_IMM,
    S_EXEC,
    S_INTACK,
    S_HALT
  } fetch_state_t;

  typedef enum logic [1:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_DEC,
    ALU_MEM
  } alu_sel_t;

  typedef struct packed {
    alu_sel_t alu_sel;
    logic     wr_ax;
    logic     wr_ip_cond;    // load ip from imm when zf is clear
    logic     wr_ip;         // load ip from shadow or vector
    logic     mem_rd;
    logic     mem_wr;
    logic     set_ifl;
    logic     clr_ifl;
    logic     ld_shadow_ip;
    logic     end_seq;
  } micro_word_t;

  typedef struct packed {
    logic zf;
    logic of;
    logic ifl;
  } flags_t;

  // microcode entry points
  localparam uaddr_t UA_NOP  = 5'd0;
  localparam uaddr_t UA_LDI  = 5'd1;
  localparam uaddr_t UA_ADDI = 5'd2;
  localparam uaddr_t UA_DEC  = 5'd3;
  localparam uaddr_t UA_LD   = 5'd4;
  localparam uaddr_t UA_ST   = 5'd5;
  localparam uaddr_t UA_JNZ  = 5'd6;
  localparam uaddr_t UA_CLI  = 5'd7;
  localparam uaddr_t UA_STI  = 5'd8;
  localparam uaddr_t UA_IRET = 5'd9;
  localparam uaddr_t UA_HLT  = 5'd11;
  localparam uaddr_t UA_INT  = 5'd12;

  localparam int ROM_DEPTH = 13;

endpackage

// ==== mini_decode.sv ====
`timescale 1ns/1ns

module mini_decode (
  input  mini_pkg::opcode_t opcode_i,
  output logic              need_imm_o,
  output mini_pkg::uaddr_t  entry_o
);

  always_comb begin
    need_imm_o = 1'b0;
    entry_o    = mini_pkg::UA_NOP;
    case (opcode_i)
      mini_pkg::OP_LDI: begin
        need_imm_o = 1'b1;
        entry_o    = mini_pkg::UA_LDI;
      end
      mini_pkg::OP_ADDI: begin
        need_imm_o = 1'b1;
        entry_o    = mini_pkg::UA_ADDI;
      end
      mini_pkg::OP_DEC: begin
        entry_o = mini_pkg::UA_DEC;
      end
      // memory operand address comes from the immediate
      mini_pkg::OP_LD: begin
        need_imm_o = 1'b1;
        entry_o    = mini_pkg::UA_LD;
      end
      mini_pkg::OP_ST: begin
        need_imm_o = 1'b1;
        entry_o    = mini_pkg::UA_ST;
      end
      mini_pkg::OP_JNZ: begin
        need_imm_o = 1'b1;
        entry_o    = mini_pkg::UA_JNZ;
      end
      mini_pkg::OP_CLI: begin
        entry_o = mini_pkg::UA_CLI;
      end
      mini_pkg::OP_STI: begin
        entry_o = mini_pkg::UA_STI;
      end
      mini_pkg::OP_IRET: begin
        entry_o = mini_pkg::UA_IRET;
      end
      mini_pkg::OP_HLT: begin
        entry_o = mini_pkg::UA_HLT;
      end
      // unknown opcodes run as nop
      default: begin
        need_imm_o = 1'b0;
        entry_o    = mini_pkg::UA_NOP;
      end
    endcase
  end

endmodule

// ==== mini_micro_seq.sv ====
`timescale 1ns/1ns

module mini_micro_seq (
  input  logic             clk,
  input  logic             rst,
  input  logic             start_i,
  input  mini_pkg::uaddr_t entry_i,
  input  logic             advance_i,
  output mini_pkg::uaddr_t uaddr_o
);

  mini_pkg::uaddr_t ucnt;

  // start wins over advance
  always_ff @(posedge clk) begin
    if (rst) begin
      ucnt <= mini_pkg::UA_NOP;
    end else if (start_i) begin
      ucnt <= entry_i;
    end else if (advance_i) begin
      ucnt <= ucnt + 5'd1;
    end
  end

  assign uaddr_o = ucnt;

  // every routine ends with end_seq before the last rom word
  a_in_rom : assert property (@(posedge clk) disable iff (rst)
    (advance_i && !start_i) |-> (int'(ucnt) < mini_pkg::ROM_DEPTH - 1));

endmodule

// ==== mini_micro_rom.sv ====
`timescale 1ns/1ns

module mini_micro_rom (
  input  mini_pkg::uaddr_t      uaddr_i,
  output mini_pkg::micro_word_t uword_o
);

  always_comb begin
    uword_o = '0;
    case (uaddr_i)
      mini_pkg::UA_LDI: begin
        uword_o.alu_sel = mini_pkg::ALU_PASS;
        uword_o.wr_ax   = 1'b1;
      end
      mini_pkg::UA_ADDI: begin
        uword_o.alu_sel = mini_pkg::ALU_ADD;
        uword_o.wr_ax   = 1'b1;
      end
      mini_pkg::UA_DEC: begin
        uword_o.alu_sel = mini_pkg::ALU_DEC;
        uword_o.wr_ax   = 1'b1;
      end
      mini_pkg::UA_LD: begin
        uword_o.alu_sel = mini_pkg::ALU_MEM;
        uword_o.mem_rd  = 1'b1;
        uword_o.wr_ax   = 1'b1;
      end
      mini_pkg::UA_ST:   uword_o.mem_wr     = 1'b1;
      mini_pkg::UA_JNZ:  uword_o.wr_ip_cond = 1'b1;
      mini_pkg::UA_CLI:  uword_o.clr_ifl    = 1'b1;
      mini_pkg::UA_STI:  uword_o.set_ifl    = 1'b1;
      // iret restores ip first, then opens interrupts again
      mini_pkg::UA_IRET: uword_o.wr_ip      = 1'b1;
      5'd10:             uword_o.set_ifl    = 1'b1;
      mini_pkg::UA_INT: begin
        uword_o.ld_shadow_ip = 1'b1;
        uword_o.wr_ip        = 1'b1;
        uword_o.clr_ifl      = 1'b1;
      end
      default: uword_o = '0;
    endcase
    // single step routines end here, iret ends on its second word
    if (uaddr_i != mini_pkg::UA_IRET) begin
      uword_o.end_seq = 1'b1;
    end
  end

endmodule

// ==== mini_fetch.sv ====
`timescale 1ns/1ns

module mini_fetch (
  input  logic                   clk,
  input  logic                   rst,
  input  mini_pkg::word_t        opcode_word_i,
  input  logic                   block_i,
  input  logic                   need_imm_i,
  input  mini_pkg::micro_word_t  uword_i,
  input  mini_pkg::flags_t       flags_i,
  input  logic                   intr_i,
  output mini_pkg::opcode_t      opcode_o,
  output mini_pkg::word_t        imm_o,
  output logic                   fetch_op_o,
  output logic                   ip_inc_o,
  output logic                   start_seq_o,
  output logic                   int_enter_o,
  output logic                   inta_o,
  output mini_pkg::fetch_state_t state_o
);

  mini_pkg::fetch_state_t fsm_state;
  mini_pkg::fetch_state_t next_state;
  mini_pkg::opcode_t      opcode_l;
  mini_pkg::word_t        imm_l;
  logic                   exec_step;
  logic                   int_pending;

  // a microstep completes when nothing holds it
  assign exec_step   = (fsm_state == mini_pkg::S_EXEC) && !block_i;
  assign int_pending = intr_i && flags_i.ifl;

  always_comb begin
    next_state  = fsm_state;
    fetch_op_o  = 1'b0;
    ip_inc_o    = 1'b0;
    start_seq_o = 1'b0;
    int_enter_o = 1'b0;
    case (fsm_state)
      mini_pkg::S_OPCODE: begin
        fetch_op_o = 1'b1;
        if (!block_i) begin
          ip_inc_o = 1'b1;
          if (need_imm_i) begin
            next_state = mini_pkg::S_IMM;
          end else begin
            next_state  = mini_pkg::S_EXEC;
            start_seq_o = 1'b1;
          end
        end
      end
      mini_pkg::S_IMM: begin
        fetch_op_o = 1'b1;
        if (!block_i) begin
          ip_inc_o    = 1'b1;
          next_state  = mini_pkg::S_EXEC;
          start_seq_o = 1'b1;
        end
      end
      mini_pkg::S_EXEC: begin
        // instruction boundary, check for an enabled interrupt
        if (exec_step && uword_i.end_seq) begin
          next_state = int_pending ? mini_pkg::S_INTACK : mini_pkg::S_OPCODE;
        end else if (block_i && opcode_l == mini_pkg::OP_HLT) begin
          next_state = mini_pkg::S_HALT;
        end
      end
      mini_pkg::S_INTACK: begin
        int_enter_o = 1'b1;
        next_state  = mini_pkg::S_OPCODE;
      end
      mini_pkg::S_HALT: begin
        if (!block_i) begin
          next_state = int_pending ? mini_pkg::S_INTACK : mini_pkg::S_OPCODE;
        end
      end
      default: next_state = mini_pkg::S_OPCODE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_state <= mini_pkg::S_OPCODE;
    end else begin
      fsm_state <= next_state;
    end
  end

  // opcode and immediate latches
  always_ff @(posedge clk) begin
    if (fsm_state == mini_pkg::S_OPCODE && !block_i) begin
      opcode_l <= opcode_word_i[15:8];
    end
    if (fsm_state == mini_pkg::S_IMM && !block_i) begin
      imm_l <= opcode_word_i;
    end
  end

  // decode sees the live opcode byte while it is on the bus
  assign opcode_o = (fsm_state == mini_pkg::S_OPCODE) ? opcode_word_i[15:8] : opcode_l;
  assign imm_o    = imm_l;
  assign inta_o   = int_enter_o;
  assign state_o  = fsm_state;

  a_start_on_entry : assert property (@(posedge clk) disable iff (rst)
    start_seq_o |-> (fsm_state != mini_pkg::S_EXEC) ##1 (fsm_state == mini_pkg::S_EXEC));

endmodule

// ==== mini_exec.sv ====
`timescale 1ns/1ns

module mini_exec (
  input  logic                  clk,
  input  logic                  rst,
  input  mini_pkg::micro_word_t uword_i,
  input  logic                  step_i,
  input  mini_pkg::word_t       imm_i,
  input  mini_pkg::word_t       mem_dat_i,
  input  logic                  ip_inc_i,
  input  logic                  int_enter_i,
  output mini_pkg::flags_t      flags_o,
  output mini_pkg::addr_t       fetch_adr_o,
  output mini_pkg::addr_t       exec_adr_o,
  output mini_pkg::word_t       wr_dat_o,
  output mini_pkg::addr_t       pc_o
);

  mini_pkg::word_t  ax;
  mini_pkg::word_t  ip;
  mini_pkg::word_t  cs;
  mini_pkg::word_t  shadow_ip;
  mini_pkg::flags_t flags_q;
  mini_pkg::word_t  alu_res;
  logic             alu_of;
  logic             upd_flags;
  logic             do_step;

  // interrupt entry runs as one microstep outside of S_EXEC
  assign do_step = step_i || int_enter_i;

  always_comb begin
    alu_res   = imm_i;
    alu_of    = 1'b0;
    upd_flags = 1'b0;
    case (uword_i.alu_sel)
      mini_pkg::ALU_ADD: begin
        alu_res   = ax + imm_i;
        alu_of    = (ax[15] == imm_i[15]) && (alu_res[15] != ax[15]);
        upd_flags = 1'b1;
      end
      mini_pkg::ALU_DEC: begin
        alu_res   = ax - 16'd1;
        alu_of    = (ax == 16'h8000);
        upd_flags = 1'b1;
      end
      mini_pkg::ALU_MEM: alu_res = mem_dat_i;
      default:           alu_res = imm_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (do_step && uword_i.wr_ax) begin
      ax <= alu_res;
    end
    if (do_step && uword_i.ld_shadow_ip) begin
      shadow_ip <= ip;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ip <= mini_pkg::RESET_IP;
    end else if (ip_inc_i) begin
      ip <= ip + 16'd1;
    end else if (do_step) begin
      if (uword_i.wr_ip) begin
        ip <= uword_i.ld_shadow_ip ? mini_pkg::INT_VECTOR : shadow_ip;
      end else if (uword_i.wr_ip_cond && !flags_q.zf) begin
        ip <= imm_i;
      end
    end
  end

  // no instruction writes cs
  always_ff @(posedge clk) begin
    if (rst) begin
      cs <= mini_pkg::RESET_CS;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else if (do_step) begin
      if (upd_flags) begin
        flags_q.zf <= (alu_res == 16'h0000);
        flags_q.of <= alu_of;
      end
      if (uword_i.set_ifl) begin
        flags_q.ifl <= 1'b1;
      end else if (uword_i.clr_ifl) begin
        flags_q.ifl <= 1'b0;
      end
    end
  end

  // physical address is cs * 16 + offset
  assign fetch_adr_o = {cs, 4'h0} + {4'h0, ip};
  assign exec_adr_o  = {cs, 4'h0} + {4'h0, imm_i};
  assign pc_o        = fetch_adr_o;
  assign wr_dat_o    = ax;
  assign flags_o     = flags_q;

endmodule

// ==== mini_core.sv ====
`timescale 1ns/1ns

module mini_core (
  input  logic            clk,
  input  logic            rst,
  input  logic            intr_i,
  output logic            inta_o,
  output mini_pkg::addr_t cpu_adr_o,
  input  mini_pkg::word_t cpu_dat_i,
  output mini_pkg::word_t cpu_dat_o,
  output logic            cpu_we_o,
  output logic            cpu_mem_op_o,
  input  logic            cpu_block_i,
  output logic            hlt_o,
  output mini_pkg::addr_t pc_o
);

  mini_pkg::opcode_t      opcode;
  mini_pkg::word_t        imm_l;
  mini_pkg::fetch_state_t fetch_state;
  mini_pkg::uaddr_t       entry;
  mini_pkg::uaddr_t       seq_uaddr;
  mini_pkg::uaddr_t       rom_uaddr;
  mini_pkg::micro_word_t  uword;
  mini_pkg::flags_t       flags;
  mini_pkg::addr_t        fetch_adr;
  mini_pkg::addr_t        exec_adr;
  logic                   need_imm;
  logic                   fetch_op;
  logic                   ip_inc;
  logic                   start_seq;
  logic                   int_enter;
  logic                   exec_mem;
  logic                   exec_step;
  logic                   block;
  logic                   hlt_op;
  logic                   hlt_op_old;
  logic                   hlt_in;
  logic                   hlt_out;
  logic                   halt;

  mini_fetch u_fetch (
    .clk           (clk),
    .rst           (rst),
    .opcode_word_i (cpu_dat_i),
    .block_i       (block),
    .need_imm_i    (need_imm),
    .uword_i       (uword),
    .flags_i       (flags),
    .intr_i        (intr_i),
    .opcode_o      (opcode),
    .imm_o         (imm_l),
    .fetch_op_o    (fetch_op),
    .ip_inc_o      (ip_inc),
    .start_seq_o   (start_seq),
    .int_enter_o   (int_enter),
    .inta_o        (inta_o),
    .state_o       (fetch_state)
  );

  mini_decode u_decode (
    .opcode_i   (opcode),
    .need_imm_o (need_imm),
    .entry_o    (entry)
  );

  mini_micro_seq u_seq (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start_seq),
    .entry_i   (entry),
    .advance_i (exec_step && !uword.end_seq),
    .uaddr_o   (seq_uaddr)
  );

  mini_micro_rom u_rom (
    .uaddr_i (rom_uaddr),
    .uword_o (uword)
  );

  mini_exec u_exec (
    .clk         (clk),
    .rst         (rst),
    .uword_i     (uword),
    .step_i      (exec_step),
    .imm_i       (imm_l),
    .mem_dat_i   (cpu_dat_i),
    .ip_inc_i    (ip_inc),
    .int_enter_i (int_enter),
    .flags_o     (flags),
    .fetch_adr_o (fetch_adr),
    .exec_adr_o  (exec_adr),
    .wr_dat_o    (cpu_dat_o),
    .pc_o        (pc_o)
  );

  assign rom_uaddr = int_enter ? mini_pkg::UA_INT : seq_uaddr;

  // bus side, quiet while in reset
  assign exec_mem     = (fetch_state == mini_pkg::S_EXEC) && (uword.mem_rd || uword.mem_wr);
  assign cpu_mem_op_o = (fetch_op || exec_mem) && !rst;
  assign cpu_we_o     = (fetch_state == mini_pkg::S_EXEC) && uword.mem_wr;
  assign cpu_adr_o    = exec_mem ? exec_adr : fetch_adr;

  // halt logic, block also covers the first hlt cycle
  assign hlt_op    = (fetch_state == mini_pkg::S_EXEC) && (opcode == mini_pkg::OP_HLT);
  assign hlt_out   = intr_i && flags.ifl;
  assign hlt_in    = hlt_op && !hlt_op_old && !hlt_out;
  assign block     = (cpu_block_i && cpu_mem_op_o) || halt || hlt_in;
  assign exec_step = (fetch_state == mini_pkg::S_EXEC) && !block;
  assign hlt_o     = halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      hlt_op_old <= 1'b0;
      halt       <= 1'b0;
    end else begin
      hlt_op_old <= hlt_op;
      if (hlt_in) begin
        halt <= 1'b1;
      end else if (hlt_out) begin
        halt <= 1'b0;
      end
    end
  end

  a_we_in_cycle : assert property (@(posedge clk) disable iff (rst)
    cpu_we_o |-> cpu_mem_op_o);

  // a halted core sits in S_HALT with the bus quiet
  a_halt_quiet : assert property (@(posedge clk) disable iff (rst)
    halt |-> (fetch_state == mini_pkg::S_HALT) && !cpu_mem_op_o);

endmodule

// ==== tb_mini_core.sv ====
`timescale 1ns/1ns

module tb_mini_core;

  logic            clk;
  logic            rst;
  logic            intr_i = 1'b0;
  logic            inta_o;
  mini_pkg::addr_t cpu_adr_o;
  mini_pkg::word_t cpu_dat_i;
  mini_pkg::word_t cpu_dat_o;
  logic            cpu_we_o;
  logic            cpu_mem_op_o;
  logic            cpu_block_i = 1'b0;
  logic            hlt_o;
  mini_pkg::addr_t pc_o;

  // memory image and expected results from the data file
  mini_pkg::word_t mem [mini_pkg::addr_t];
  mini_pkg::addr_t exp_adr [$];
  mini_pkg::word_t exp_dat [$];
  mini_pkg::addr_t exp_pc;
  int              int_trigger = 0;
  logic            load_done = 1'b0;

  // bus monitor state
  integer          seed = 32'h9798545b;
  logic [31:0]     rnd;
  int              widx = 0;
  int              inta_count = 0;
  logic            intr_sent = 1'b0;
  logic            late_intr = 1'b0;
  logic            prev_pending = 1'b0;
  mini_pkg::addr_t prev_adr;
  mini_pkg::word_t prev_dat;
  logic            prev_we;
  logic            prev_inta = 1'b0;
  logic            vector_due = 1'b0;

  mini_core UUT (
    .clk          (clk),
    .rst          (rst),
    .intr_i       (intr_i),
    .inta_o       (inta_o),
    .cpu_adr_o    (cpu_adr_o),
    .cpu_dat_i    (cpu_dat_i),
    .cpu_dat_o    (cpu_dat_o),
    .cpu_we_o     (cpu_we_o),
    .cpu_mem_op_o (cpu_mem_op_o),
    .cpu_block_i  (cpu_block_i),
    .hlt_o        (hlt_o),
    .pc_o         (pc_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_addr(input mini_pkg::addr_t got, input mini_pkg::addr_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at time %0t: %s is %05h, expected %05h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_word(input mini_pkg::word_t got, input mini_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at time %0t: %s is %04h, expected %04h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // segment times 16 plus offset
  function automatic mini_pkg::addr_t phys_addr(input mini_pkg::word_t seg,
                                               input mini_pkg::word_t off);
    return (mini_pkg::addr_t'(seg) << 4) + mini_pkg::addr_t'(off);
  endfunction

  function automatic mini_pkg::word_t fill_word(input mini_pkg::addr_t a);
    return a[19:4] ^ {a[3:0], 12'h5A5};
  endfunction

  task automatic load_testdata();
    int               fd;
    int               code;
    logic [7:0]       kind;
    logic [31:0]      f_a;
    logic [31:0]      f_b;
    logic [8*128-1:0] skip_line;
    fd = $fopen("mini_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open mini_testdata.txt");
    end
    code = $fscanf(fd, " %c", kind);
    while (code == 1) begin
      case (kind)
        "#": code = $fgets(skip_line, fd);
        "M": begin
          code = $fscanf(fd, "%h %h", f_a, f_b);
          mem[f_a[19:0]] = f_b[15:0];
        end
        "W": begin
          code = $fscanf(fd, "%h %h", f_a, f_b);
          exp_adr.push_back(f_a[19:0]);
          exp_dat.push_back(f_b[15:0]);
        end
        "T": code = $fscanf(fd, "%d", int_trigger);
        "P": begin
          code = $fscanf(fd, "%h", f_a);
          exp_pc = f_a[19:0];
        end
        default: abort_run($sformatf("unknown record kind %c in mini_testdata.txt", kind));
      endcase
      code = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);
    load_done = 1'b1;
  endtask

  // combinational read port
  always @(cpu_adr_o or load_done) begin
    if (mem.exists(cpu_adr_o)) begin
      cpu_dat_i = mem[cpu_adr_o];
    end else begin
      cpu_dat_i = fill_word(cpu_adr_o);
    end
  end

  // stall generator, bus monitor and interrupt driver
  always @(posedge clk) begin
    rnd = $random(seed);
    cpu_block_i <= (rnd[1:0] == 2'b00);
    if (rst) begin
      prev_pending = 1'b0;
      prev_inta    = 1'b0;
      vector_due   = 1'b0;
    end else begin
      // a blocked cycle comes back unchanged
      if (prev_pending) begin
        check_bit(cpu_mem_op_o, 1'b1, "bus request after a blocked clock");
        check_addr(cpu_adr_o, prev_adr, "address after a blocked clock");
        check_bit(cpu_we_o, prev_we, "cpu_we_o after a blocked clock");
        if (prev_we) begin
          check_word(cpu_dat_o, prev_dat, "write data after a blocked clock");
        end
      end
      if (hlt_o) begin
        check_bit(cpu_mem_op_o, 1'b0, "bus request while halted");
      end
      if (cpu_mem_op_o && !cpu_block_i && cpu_we_o) begin
        if (widx >= exp_adr.size()) begin
          abort_run($sformatf("write to %05h beyond the expected list", cpu_adr_o));
        end
        check_addr(cpu_adr_o, exp_adr[widx], $sformatf("address of write %0d", widx));
        check_word(cpu_dat_o, exp_dat[widx], $sformatf("data of write %0d", widx));
        widx++;
      end
      if (vector_due) begin
        check_addr(cpu_adr_o, phys_addr(mini_pkg::RESET_CS, mini_pkg::INT_VECTOR),
                   "fetch address after inta_o");
      end
      if (inta_o) begin
        check_bit(intr_sent, 1'b1, "inta_o with no intr_i raised");
        check_bit(prev_inta, 1'b0, "inta_o in the clock before");
        inta_count++;
        intr_i <= 1'b0;
      end else if (late_intr) begin
        // held high over the final halt while ifl is clear
        intr_i <= 1'b1;
      end else if (!intr_sent && widx >= int_trigger && hlt_o) begin
        // raised only once the core sits halted
        intr_i <= 1'b1;
        intr_sent = 1'b1;
      end
      prev_pending = cpu_mem_op_o && cpu_block_i;
      prev_adr     = cpu_adr_o;
      prev_dat     = cpu_dat_o;
      prev_we      = cpu_we_o;
      vector_due   = inta_o;
      prev_inta    = inta_o;
    end
  end

  initial begin : main
    int cycles;
    rst = 1'b1;
    load_testdata();
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_bit(cpu_mem_op_o, 1'b0, "cpu_mem_op_o in reset");
    check_bit(cpu_we_o, 1'b0, "cpu_we_o in reset");
    check_bit(inta_o, 1'b0, "inta_o in reset");
    check_bit(hlt_o, 1'b0, "hlt_o in reset");
    @(posedge clk);
    rst <= 1'b0;

    // first fetch from the reset address
    cycles = 0;
    @(negedge clk);
    while (!cpu_mem_op_o) begin
      cycles++;
      if (cycles > 50) begin
        abort_run("no bus cycle started after reset");
      end
      @(negedge clk);
    end
    check_addr(cpu_adr_o, phys_addr(mini_pkg::RESET_CS, mini_pkg::RESET_IP),
               "first bus address");
    check_bit(cpu_we_o, 1'b0, "cpu_we_o of the first bus cycle");

    // loop, arithmetic and STI then HLT
    cycles = 0;
    while (!(hlt_o && widx >= int_trigger)) begin
      cycles++;
      if (cycles > 3000) begin
        abort_run("core did not halt after the first writes");
      end
      @(negedge clk);
    end

    cycles = 0;
    while (inta_count == 0) begin
      cycles++;
      if (cycles > 200) begin
        abort_run("no inta_o pulse after intr_i was raised");
      end
      @(negedge clk);
    end

    // handler, IRET and the final halt
    cycles = 0;
    while (!(hlt_o && widx == exp_adr.size())) begin
      cycles++;
      if (cycles > 3000) begin
        abort_run("core did not reach the final halt with all writes done");
      end
      @(negedge clk);
    end

    // ifl is clear so the halt must hold with intr_i raised
    late_intr = 1'b1;
    repeat (20) begin
      @(negedge clk);
      check_bit(hlt_o, 1'b1, "hlt_o during the final halt");
    end
    if (inta_count != 1) begin
      abort_run($sformatf("expected one inta_o pulse, saw %0d", inta_count));
    end else begin
      check_addr(pc_o, exp_pc, "pc_o at the final halt");
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// ==== mini_testdata.txt ====
# M addr word = memory preload, W addr data = expected write in order
# T n = intr_i armed after n writes and raised once halted, P addr = pc_o at final halt
M 00100 B800
M 00101 0003
M 00102 A300
M 00103 0200
M 00104 4800
M 00105 7500
M 00106 0102
M 00107 0500
M 00108 7FFF
M 00109 0500
M 0010A 0001
M 0010B A300
M 0010C 0201
M 0010D A100
M 0010E 0300
M 0010F A300
M 00110 0202
M 00111 FB00
M 00112 F400
M 00113 A300
M 00114 0204
M 00115 FA00
M 00116 F400
M 00040 B800
M 00041 5555
M 00042 A300
M 00043 0203
M 00044 CF00
M 00300 1234
W 00200 0003
W 00200 0002
W 00200 0001
W 00201 8000
W 00202 1234
W 00203 5555
W 00204 5555
T 5
P 00117

// ==== project.f ====
mini_pkg.sv
mini_decode.sv
mini_micro_seq.sv
mini_micro_rom.sv
mini_fetch.sv
mini_exec.sv
mini_core.sv
tb_mini_core.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_mini_core -f project.f
	@out="$$(./obj_dir/Vtb_mini_core)"; echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
